/* flist.f */
verilog/isa_pkg.sv
verilog/exu_pkg.sv
verilog/alu_unit.sv
verilog/shift_unit.sv
verilog/booth_mult.sv
verilog/exu_ctrl.sv
verilog/exec_unit.sv
verif/tb_clkgen.sv
verif/exec_unit_sva.sv
verif/tb_exec_unit.sv

/* run_sim.sh */
#!/bin/sh
set -e

# Build DUT, assertions and testbench
verilator --binary --timing --assert --timescale 1ns/10ps \
   --top-module tb_exec_unit -f flist.f

# Run and keep the log
./obj_dir/Vtb_exec_unit | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
   exit 1
fi

# A run stopped early by an assertion has no pass line
if ! grep -q "SIMULATION PASSED" sim.log; then
   echo "Simulation ended without a pass line"
   exit 1
fi

exit 0

/* verif/exec_unit_sva.sv */
`timescale 1ns/10ps

module exec_unit_sva
   import exu_pkg::*;
(
   input logic clk,
   input logic rst_n,
   input logic op_valid,
   input logic busy,
   input logic result_valid,
   input logic alu_start,
   input logic shift_start,
   input logic mult_start,
   input logic mult_done
);

   logic any_start;

   // Any unit kicked off
   assign any_start = alu_start | shift_start | mult_start;

   // --------------------
   // Handshake
   // --------------------
   a_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      result_valid |=> !result_valid)
      else $error("result_valid stayed high for more than one cycle");

   // Start only follows an accept made while idle
   a_accept_idle: assert property (@(posedge clk) disable iff (!rst_n)
      any_start |-> $past(op_valid && !busy))
      else $error("unit started without an idle accept");

   // --------------------
   // Multiplier latency
   // --------------------
   a_mult_done: assert property (@(posedge clk) disable iff (!rst_n)
      $past(mult_start, BOOTH_STEPS) |-> mult_done)
      else $error("mult_done missing BOOTH_STEPS cycles after mult_start");

   a_mult_start: assert property (@(posedge clk) disable iff (!rst_n)
      mult_done |-> $past(mult_start, BOOTH_STEPS))
      else $error("mult_done without mult_start BOOTH_STEPS cycles before");

endmodule

bind exec_unit exec_unit_sva u_sva (
   .clk          (clk),
   .rst_n        (rst_n),
   .op_valid     (op_valid),
   .busy         (busy),
   .result_valid (result_valid),
   .alu_start    (alu_start),
   .shift_start  (shift_start),
   .mult_start   (mult_start),
   .mult_done    (mult_done)
);

/* verif/tb_clkgen.sv */
`timescale 1ns/10ps

module tb_clkgen
(
   output logic clk,
   output logic rst_n
);

   localparam int HALF_PERIOD  = 50;
   localparam int RESET_CYCLES = 16;

   // 100 ns clock
   initial
   begin
      clk = 1'b0;
      forever
         #HALF_PERIOD clk = ~clk;
   end

   // Reset low for 16 cycles, released on a rising edge
   initial
   begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
   end

endmodule

/* verif/tb_exec_unit.sv */
`timescale 1ns/10ps

module tb_exec_unit
   import isa_pkg::*;
();

   localparam int RESET_CYCLES   = 16;
   localparam int SINGLE_LATENCY = 2;
   localparam int N_ALU   = 44;
   localparam int N_SHIFT = 48;
   localparam int N_MULT  = 80;
   localparam int N_NOISE = 20;
   localparam int N_MIX   = 40;
   localparam int TOTAL_OPS = N_ALU + N_SHIFT + N_MULT + N_NOISE + N_MIX;
   // 12 cycles per op plus reset and idle gaps
   localparam int WATCHDOG_CYCLES = TOTAL_OPS * 12 + RESET_CYCLES + 64;

   localparam op_t ALU_OPS[5] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR};
   localparam op_t SHIFT_OPS[3] = '{OP_SLL, OP_SRL, OP_SRA};
   localparam op_t ALL_OPS[10] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
                                   OP_SLL, OP_SRL, OP_SRA, OP_MULL, OP_MULH};
   localparam word_t CORNERS[5] = '{16'h0000, 16'h0001, 16'hFFFF, 16'h7FFF, 16'h8000};
   localparam int AMTS[3] = '{0, 1, 15};

   logic  clk;
   logic  rst_n;
   logic  op_valid;
   op_t   op_code;
   word_t op_a;
   word_t op_b;
   tag_t  op_tag;
   logic  busy;
   logic  result_valid;
   word_t result;
   tag_t  result_tag;

   logic [15:0] lfsr_q;
   tag_t        next_tag;
   int          issued_count;
   int          stim_errors;
   int          stim_checks;
   int          test_err0;
   int          test_chk0;
   // Monitor side
   int          mon_errors;
   int          mon_checks;
   int          mon_accepts;
   int          cycle_cnt;
   word_t       exp_val_q[$];
   tag_t        exp_tag_q[$];
   op_t         exp_op_q[$];
   int          exp_cyc_q[$];

   tb_clkgen u_clkgen (
      .clk   (clk),
      .rst_n (rst_n)
   );

   exec_unit UUT (
      .clk          (clk),
      .rst_n        (rst_n),
      .op_valid     (op_valid),
      .op_code      (op_code),
      .op_a         (op_a),
      .op_b         (op_b),
      .op_tag       (op_tag),
      .busy         (busy),
      .result_valid (result_valid),
      .result       (result),
      .result_tag   (result_tag)
   );

   // --------------------
   // Random source
   // --------------------

   // 16-bit Galois LFSR with polynomial x^16+x^14+x^13+x^11+1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      if (s[0])
         return (s >> 1) ^ 16'hB400;
      else
         return s >> 1;
   endfunction

   // One step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr_q = lfsr_next(lfsr_q);
         r = {r[30:0], lfsr_q[0]};
      end
      return r;
   endfunction

   function automatic word_t rand_word();
      return word_t'(rand_bits(16));
   endfunction

   // --------------------
   // Reference model
   // --------------------
   function automatic word_t expected_result(input op_t op, input word_t a, input word_t b);
      logic signed [31:0] prod;
      prod = 32'($signed(a)) * 32'($signed(b));
      case (op)
         OP_ADD:  return a + b;
         OP_SUB:  return a - b;
         OP_AND:  return a & b;
         OP_OR:   return a | b;
         OP_XOR:  return a ^ b;
         OP_SLL:  return a << b[3:0];
         OP_SRL:  return a >> b[3:0];
         OP_SRA:  return word_t'($signed(a) >>> b[3:0]);
         OP_MULL: return prod[15:0];
         OP_MULH: return prod[31:16];
         default: return '0;
      endcase
   endfunction

   // --------------------
   // Stimulus tasks
   // --------------------
   task automatic drive_op(input op_t op, input word_t a, input word_t b, input tag_t tag);
      op_valid <= 1'b1;
      op_code  <= op;
      op_a     <= a;
      op_b     <= b;
      op_tag   <= tag;
   endtask

   // Entered on a rising edge and returns right after the accept edge
   task automatic issue_op(input op_t op, input word_t a, input word_t b, input bit noise);
      bit   accepted;
      tag_t tag;
      accepted = 1'b0;
      tag = next_tag;
      next_tag = next_tag + 3'd1;
      drive_op(op, a, b, tag);
      while (!accepted)
      begin
         @(negedge clk);
         if (!busy)
         begin
            @(posedge clk);
            accepted = 1'b1;
         end
         else if (result_valid)
         begin
            // Busy falls at this edge so the real op goes back on the inputs
            @(posedge clk);
            drive_op(op, a, b, tag);
         end
         else
         begin
            @(posedge clk);
            if (noise)
               drive_op(ALL_OPS[rand_bits(8) % 10], rand_word(), rand_word(),
                        tag_t'(rand_bits(3)));
         end
      end
      issued_count++;
   endtask

   // Idle the inputs and wait for all results
   task automatic drain();
      op_valid <= 1'b0;
      do
         @(posedge clk);
      while (exp_val_q.size() != 0);
      repeat (2) @(posedge clk);
   endtask

   task automatic start_test();
      test_err0 = mon_errors + stim_errors;
      test_chk0 = mon_checks + stim_checks;
   endtask

   task automatic report_test(input int num, input string name);
      int errs;
      int chks;
      errs = mon_errors + stim_errors - test_err0;
      chks = mon_checks + stim_checks - test_chk0;
      $display("Test %0d %s: %0d checks, %0d errors", num, name, chks, errs);
   endtask

   // --------------------
   // Monitor and checker
   // --------------------

   // Sampled on the falling edge where inputs and outputs are settled
   always @(negedge clk)
   begin : monitor
      word_t e_val;
      tag_t  e_tag;
      op_t   e_op;
      int    lat;
      int    e_lat;
      if (rst_n)
      begin
         cycle_cnt++;
         // Busy from the cycle after accept through the result cycle
         if (busy !== (exp_val_q.size() != 0))
         begin
            $display("[ERROR] %0t: busy %b with %0d operations outstanding",
                     $time, busy, exp_val_q.size());
            mon_errors++;
         end
         if (result_valid)
         begin
            if (exp_val_q.size() == 0)
            begin
               $display("Unexpected result_valid at %0t with no operation outstanding", $time);
               mon_errors++;
            end
            else
            begin
               e_val = exp_val_q.pop_front();
               e_tag = exp_tag_q.pop_front();
               e_op  = exp_op_q.pop_front();
               lat   = cycle_cnt - exp_cyc_q.pop_front();
               e_lat = (e_op == OP_MULL || e_op == OP_MULH) ? MUL_LATENCY : SINGLE_LATENCY;
               mon_checks++;
               if (result !== e_val)
               begin
                  $display("[ERROR] %0t: %s result %h, expected %h",
                           $time, e_op.name(), result, e_val);
                  mon_errors++;
               end
               if (result_tag !== e_tag)
               begin
                  $display("[ERROR] %0t: result_tag %0d, expected %0d", $time, result_tag, e_tag);
                  mon_errors++;
               end
               if (lat != e_lat)
               begin
                  $display("[ERROR] %0t: %s latency %0d, expected %0d",
                           $time, e_op.name(), lat, e_lat);
                  mon_errors++;
               end
            end
         end
         // Accepted at the coming rising edge
         if (op_valid && !busy)
         begin
            mon_accepts++;
            exp_val_q.push_back(expected_result(op_code, op_a, op_b));
            exp_tag_q.push_back(op_tag);
            exp_op_q.push_back(op_code);
            exp_cyc_q.push_back(cycle_cnt);
         end
      end
   end

   // --------------------
   // Test sequence
   // --------------------
   initial
   begin : stimulus
      word_t a;
      word_t b;
      int    errors;
      op_valid     = 1'b0;
      op_code      = OP_ADD;
      op_a         = '0;
      op_b         = '0;
      op_tag       = '0;
      lfsr_q       = 16'd44;
      next_tag     = '0;
      issued_count = 0;
      stim_errors  = 0;
      stim_checks  = 0;
      mon_errors   = 0;
      mon_checks   = 0;
      mon_accepts  = 0;
      cycle_cnt    = 0;
      wait (rst_n === 1'b1);
      @(posedge clk);

      // Outputs quiet until the first op
      start_test();
      repeat (8)
      begin
         @(negedge clk);
         stim_checks++;
         if (busy !== 1'b0 || result_valid !== 1'b0 || result !== '0 || result_tag !== '0)
         begin
            $display("[ERROR] %0t: after reset busy=%b result_valid=%b result=%h tag=%0d",
                     $time, busy, result_valid, result, result_tag);
            stim_errors++;
         end
      end
      @(posedge clk);
      report_test(1, "reset idle");

      // Wrap corners, then random ALU ops
      start_test();
      issue_op(OP_ADD, 16'hFFFF, 16'h0001, 1'b0);
      issue_op(OP_ADD, 16'h7FFF, 16'h0001, 1'b0);
      issue_op(OP_SUB, 16'h0000, 16'h0001, 1'b0);
      issue_op(OP_SUB, 16'h8000, 16'h0001, 1'b0);
      repeat (N_ALU - 4)
      begin
         a = rand_word();
         b = rand_word();
         issue_op(ALU_OPS[rand_bits(8) % 5], a, b, 1'b0);
      end
      drain();
      report_test(2, "ALU");

      // Amounts 0, 1 and 15 with both signs and random upper op_b bits
      start_test();
      for (int s = 0; s < 3; s++)
         for (int m = 0; m < 3; m++)
            for (int n = 0; n < 2; n++)
            begin
               a = rand_word();
               a[15] = n[0];
               b = rand_word();
               b[3:0] = 4'(AMTS[m]);
               issue_op(SHIFT_OPS[s], a, b, 1'b0);
            end
      repeat (N_SHIFT - 18)
      begin
         a = rand_word();
         b = rand_word();
         issue_op(SHIFT_OPS[rand_bits(8) % 3], a, b, 1'b0);
      end
      drain();
      report_test(3, "shifter");

      // Every corner pairing, then random pairs
      start_test();
      for (int i = 0; i < 5; i++)
         for (int j = 0; j < 5; j++)
         begin
            issue_op(OP_MULL, CORNERS[i], CORNERS[j], 1'b0);
            issue_op(OP_MULH, CORNERS[i], CORNERS[j], 1'b0);
         end
      repeat (N_MULT - 50)
      begin
         a = rand_word();
         b = rand_word();
         issue_op(rand_bits(1) ? OP_MULH : OP_MULL, a, b, 1'b0);
      end
      drain();
      report_test(4, "multiplier");

      // Junk on the inputs while busy
      start_test();
      repeat (N_NOISE)
      begin
         a = rand_word();
         b = rand_word();
         issue_op(ALL_OPS[rand_bits(8) % 10], a, b, 1'b1);
      end
      drain();
      report_test(5, "ignored while busy");

      // op_valid never drops between ops
      start_test();
      repeat (N_MIX)
      begin
         a = rand_word();
         b = rand_word();
         issue_op(ALL_OPS[rand_bits(8) % 10], a, b, 1'b0);
      end
      drain();
      report_test(6, "back-to-back mix");

      if (mon_accepts != issued_count || mon_checks != issued_count)
      begin
         $display("Operation count mismatch: %0d issued, %0d accepted, %0d results",
                  issued_count, mon_accepts, mon_checks);
         stim_errors++;
      end
      errors = mon_errors + stim_errors;
      $display("Summary: 6 tests, %0d operations, %0d checks, %0d errors",
               issued_count, mon_checks + stim_checks, errors);
      if (errors == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

   // --------------------
   // Watchdog
   // --------------------
   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("SIMULATION FAILED");
      $finish;
   end

endmodule

/* verilog/alu_unit.sv */
`timescale 1ns/10ps

module alu_unit
   import isa_pkg::*;
(
   input  logic  clk,
   input  logic  rst_n,
   input  logic  start,
   input  op_t   op_code,
   input  word_t a,
   input  word_t b,
   output word_t result
);

   // --------------------
   // Result register
   // --------------------

   // Loaded only on the start pulse, held until the next one
   // Add and subtract wrap at 16 bits
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         result <= '0;
      else if (start)
      begin
         case (op_code)
            OP_ADD:
               result <= a + b;
            OP_SUB:
               result <= a - b;
            OP_AND:
               result <= a & b;
            OP_OR:
               result <= a | b;
            OP_XOR:
               result <= a ^ b;
            // Not an ALU op, keep last value
            default:
               result <= result;
         endcase
      end
   end

endmodule

/* verilog/booth_mult.sv */
`timescale 1ns/10ps

module booth_mult
   import isa_pkg::*, exu_pkg::*;
(
   input  logic   clk,
   input  logic   rst_n,
   input  logic   start,
   input  word_t  multiplier,
   input  word_t  multiplicand,
   output dword_t product,
   output logic   done
);

   // Partial product layout
   // [34:17] 18-bit accumulator, [16:1] multiplier, [0] guard bit
   logic [34:0] prod_q;
   logic [34:0] cur;
   logic [34:0] prod_nx;
   // Multiplicand and twice the multiplicand, sign extended to 18 bits
   logic [17:0] mand1_q, mand2_q;
   logic [17:0] m1, m2;
   logic [17:0] sum;
   step_cnt_t   cnt_q;
   logic        step_en;
   logic        last_step;

   // --------------------
   // Step operands
   // --------------------

   // First step runs in the start cycle straight from the inputs
   always_comb
   begin
      if (start)
      begin
         cur = {18'd0, multiplier, 1'b0};
         m1  = {{2{multiplicand[15]}}, multiplicand};
         m2  = {multiplicand[15], multiplicand, 1'b0};
      end
      else
      begin
         cur = prod_q;
         m1  = mand1_q;
         m2  = mand2_q;
      end
   end

   // --------------------
   // Booth recode and add
   // --------------------
   always_comb
   begin
      case (cur[2:0])
         3'b001, 3'b010:
            sum = cur[34:17] + m1;
         3'b011:
            sum = cur[34:17] + m2;
         3'b100:
            sum = cur[34:17] - m2;
         3'b101, 3'b110:
            sum = cur[34:17] - m1;
         // 000 and 111 add nothing
         default:
            sum = cur[34:17];
      endcase
   end

   // Arithmetic shift right by two
   assign prod_nx = {sum[17], sum[17], sum, cur[16:2]};

   // Busy while the counter is non-zero
   assign step_en   = start | (cnt_q != '0);
   assign last_step = (cnt_q == step_cnt_t'(BOOTH_STEPS - 1));

   // --------------------
   // Counter and product
   // --------------------
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         cnt_q  <= '0;
         done   <= 1'b0;
         prod_q <= '0;
      end
      else
      begin
         // Pulse after the eighth step
         done <= last_step;
         if (start)
            cnt_q <= step_cnt_t'(1);
         else if (last_step)
            cnt_q <= '0;
         else if (cnt_q != '0)
            cnt_q <= cnt_q + step_cnt_t'(1);
         // Product freezes once the run ends
         if (step_en)
            prod_q <= prod_nx;
      end
   end

   // Multiplicand copies for steps two to eight
   always_ff @(posedge clk)
   begin
      if (start)
      begin
         mand1_q <= m1;
         mand2_q <= m2;
      end
   end

   // Drop guard bit and top two sign bits
   assign product = prod_q[32:1];

endmodule

/* verilog/exec_unit.sv */
`timescale 1ns/10ps

module exec_unit
   import isa_pkg::*;
(
   input  logic  clk,
   input  logic  rst_n,
   input  logic  op_valid,
   input  op_t   op_code,
   input  word_t op_a,
   input  word_t op_b,
   input  tag_t  op_tag,
   output logic  busy,
   output logic  result_valid,
   output word_t result,
   output tag_t  result_tag
);

   // Start pulses
   logic   alu_start;
   logic   shift_start;
   logic   mult_start;
   // Latched operation
   word_t  opr_a;
   word_t  opr_b;
   op_t    opr_code;
   // Unit results
   word_t  alu_result;
   word_t  shift_result;
   dword_t mult_product;
   logic   mult_done;

   // --------------------
   // Control
   // --------------------
   exu_ctrl u_ctrl (
      .clk          (clk),
      .rst_n        (rst_n),
      .op_valid     (op_valid),
      .op_code      (op_code),
      .op_a         (op_a),
      .op_b         (op_b),
      .op_tag       (op_tag),
      .busy         (busy),
      .result_valid (result_valid),
      .result       (result),
      .result_tag   (result_tag),
      .alu_start    (alu_start),
      .shift_start  (shift_start),
      .mult_start   (mult_start),
      .opr_a        (opr_a),
      .opr_b        (opr_b),
      .opr_code     (opr_code),
      .alu_result   (alu_result),
      .shift_result (shift_result),
      .mult_product (mult_product),
      .mult_done    (mult_done)
   );

   // --------------------
   // Datapath units
   // --------------------
   alu_unit u_alu (
      .clk     (clk),
      .rst_n   (rst_n),
      .start   (alu_start),
      .op_code (opr_code),
      .a       (opr_a),
      .b       (opr_b),
      .result  (alu_result)
   );

   shift_unit u_shift (
      .clk     (clk),
      .rst_n   (rst_n),
      .start   (shift_start),
      .op_code (opr_code),
      .a       (opr_a),
      .b       (opr_b),
      .result  (shift_result)
   );

   // op_a is the multiplier, op_b the multiplicand
   booth_mult u_mult (
      .clk          (clk),
      .rst_n        (rst_n),
      .start        (mult_start),
      .multiplier   (opr_a),
      .multiplicand (opr_b),
      .product      (mult_product),
      .done         (mult_done)
   );

endmodule

/* verilog/exu_ctrl.sv */
`timescale 1ns/10ps

module exu_ctrl
   import isa_pkg::*, exu_pkg::*;
(
   input  logic   clk,
   input  logic   rst_n,
   input  logic   op_valid,
   input  op_t    op_code,
   input  word_t  op_a,
   input  word_t  op_b,
   input  tag_t   op_tag,
   output logic   busy,
   output logic   result_valid,
   output word_t  result,
   output tag_t   result_tag,
   output logic   alu_start,
   output logic   shift_start,
   output logic   mult_start,
   output word_t  opr_a,
   output word_t  opr_b,
   output op_t    opr_code,
   input  word_t  alu_result,
   input  word_t  shift_result,
   input  dword_t mult_product,
   input  logic   mult_done
);

   exu_state_t state, state_nx;
   unit_sel_t  dec_sel;
   unit_sel_t  sel_q;
   logic       accept;

   // --------------------
   // Decode and accept
   // --------------------
   always_comb
   begin
      case (op_code)
         OP_SLL, OP_SRL, OP_SRA:
            dec_sel = U_SHIFT;
         OP_MULL, OP_MULH:
            dec_sel = U_MULT;
         default:
            dec_sel = U_ALU;
      endcase
   end

   // op_valid ignored unless idle
   assign accept = (state == S_IDLE) && op_valid;

   // --------------------
   // Next state
   // --------------------
   always_comb
   begin
      state_nx = state;
      case (state)
         S_IDLE:
            if (accept)
               state_nx = (dec_sel == U_MULT) ? S_MULT : S_SINGLE;
         // Start cycle, unit result lands at its end
         S_SINGLE:
            state_nx = S_WB;
         // Done cycle doubles as the writeback cycle
         S_MULT:
            if (mult_done)
               state_nx = S_IDLE;
         S_WB:
            state_nx = S_IDLE;
         default:
            state_nx = S_IDLE;
      endcase
   end

   // --------------------
   // Control registers
   // --------------------
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state       <= S_IDLE;
         sel_q       <= U_ALU;
         result_tag  <= '0;
         alu_start   <= 1'b0;
         shift_start <= 1'b0;
         mult_start  <= 1'b0;
      end
      else
      begin
         state <= state_nx;
         // One-cycle start pulses, right after accept
         alu_start   <= accept && (dec_sel == U_ALU);
         shift_start <= accept && (dec_sel == U_SHIFT);
         mult_start  <= accept && (dec_sel == U_MULT);
         if (accept)
         begin
            sel_q      <= dec_sel;
            result_tag <= op_tag;
         end
      end
   end

   // Operands and opcode captured at accept
   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         opr_a    <= op_a;
         opr_b    <= op_b;
         opr_code <= op_code;
      end
   end

   // --------------------
   // Writeback
   // --------------------
   assign busy         = (state != S_IDLE);
   assign result_valid = (state == S_WB) || ((state == S_MULT) && mult_done);

   // Unit outputs are registered, so the select is a plain mux
   always_comb
   begin
      case (sel_q)
         U_SHIFT:
            result = shift_result;
         // High or low half by latched opcode
         U_MULT:
            result = (opr_code == OP_MULH) ? mult_product[31:16] : mult_product[15:0];
         default:
            result = alu_result;
      endcase
   end

endmodule

/* verilog/exu_pkg.sv */
package exu_pkg;

   // --------------------
   // Control FSM
   // --------------------
   typedef enum logic [1:0] {
      S_IDLE   = 2'd0,
      S_SINGLE = 2'd1,
      S_MULT   = 2'd2,
      S_WB     = 2'd3
   } exu_state_t;

   // --------------------
   // Unit select
   // --------------------
   typedef logic [1:0] unit_sel_t;

   localparam unit_sel_t U_ALU   = 2'd0;
   localparam unit_sel_t U_SHIFT = 2'd1;
   localparam unit_sel_t U_MULT  = 2'd2;

   // --------------------
   // Booth multiplier
   // --------------------

   // Radix-4 steps for a 16-bit multiplier
   localparam int BOOTH_STEPS = 8;
   typedef logic [3:0] step_cnt_t;

endpackage

/* verilog/isa_pkg.sv */
package isa_pkg;

   // --------------------
   // Data widths
   // --------------------

   // Operand and result word
   typedef logic [15:0] word_t;
   // Full signed product of two words
   typedef logic signed [31:0] dword_t;
   // Destination register index
   typedef logic [2:0] tag_t;
   // Shift amount, low nibble of op_b
   typedef logic [3:0] shamt_t;

   // --------------------
   // Opcodes
   // --------------------
   typedef enum logic [3:0] {
      OP_ADD  = 4'd0,
      OP_SUB  = 4'd1,
      OP_AND  = 4'd2,
      OP_OR   = 4'd3,
      OP_XOR  = 4'd4,
      OP_SLL  = 4'd5,
      OP_SRL  = 4'd6,
      OP_SRA  = 4'd7,
      OP_MULL = 4'd8,
      OP_MULH = 4'd9
   } op_t;

   // Accept edge to result_valid for MULL and MULH
   localparam int MUL_LATENCY = 9;

endpackage

/* verilog/shift_unit.sv */
`timescale 1ns/10ps

module shift_unit
   import isa_pkg::*;
(
   input  logic  clk,
   input  logic  rst_n,
   input  logic  start,
   input  op_t   op_code,
   input  word_t a,
   input  word_t b,
   output word_t result
);

   shamt_t amt;
   logic   is_left;
   logic   fill;
   word_t  s0, s1, s2, s3, s4;
   word_t  shifted;

   // Mirror a word, so one right shifter serves both directions
   function automatic word_t bit_rev(input word_t v);
      word_t r;
      for (int i = 0; i < 16; i++)
         r[i] = v[15 - i];
      return r;
   endfunction

   assign amt     = b[3:0];
   assign is_left = (op_code == OP_SLL);
   // Sign fill only for SRA
   assign fill    = (op_code == OP_SRA) & a[15];

   // --------------------
   // Four mux stages
   // --------------------
   assign s0 = is_left ? bit_rev(a) : a;
   assign s1 = amt[0] ? {fill, s0[15:1]} : s0;
   assign s2 = amt[1] ? {{2{fill}}, s1[15:2]} : s1;
   assign s3 = amt[2] ? {{4{fill}}, s2[15:4]} : s2;
   assign s4 = amt[3] ? {{8{fill}}, s3[15:8]} : s3;
   // Undo the mirror for left shifts
   assign shifted = is_left ? bit_rev(s4) : s4;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         result <= '0;
      else if (start)
         result <= shifted;
   end

endmodule
